/* rtl/obj_pkg.sv */
`default_nettype none

package obj_pkg;

    // plain vector types
    typedef logic [11:0] coord_t;
    typedef logic [12:0] tile_code_t;
    typedef logic [7:0]  color_t;
    typedef logic [7:0]  zoom_t;
    typedef logic [15:0] mask16_t;
    typedef logic [14:0] ram_addr_t;
    typedef logic [9:0]  entry_idx_t;

    // sprite list walk
    localparam int NUM_ENTRIES     = 835;
    localparam int WORDS_PER_ENTRY = 8;
    localparam int PRE_READ_WAIT   = 13;

    // horizontal timing in pixels
    localparam int H_TOTAL    = 424;
    localparam int HB_START   = 320;
    localparam int HB_END     = 8;
    localparam int HS_START   = 340;
    localparam int HS_LEN     = 64;
    localparam int HS_LEN_FIX = 32;

    // vertical timing in lines
    localparam int V_TOTAL    = 262;
    localparam int VB_START   = 224;
    localparam int VS_START   = 240;
    localparam int VS_LEN     = 6;
    localparam int VS_LEN_FIX = 4;

    // placement limits and flip origins
    localparam coord_t SCREEN_X_MAX  = 12'd480;
    localparam coord_t SCREEN_Y_MAX  = 12'd240;
    localparam coord_t FLIP_X_ORIGIN = 12'd496;
    localparam coord_t FLIP_Y_ORIGIN = 12'd240;

    // decoded attribute entry
    typedef struct packed {
        tile_code_t tile_code;
        zoom_t      x_zoom;
        zoom_t      y_zoom;
        coord_t     x_coord;
        coord_t     y_coord;
        color_t     color;
        logic       latch_extra;
        logic       latch_master;
        logic       use_extra;
        logic       use_scroll;
        logic       x_flip;
        logic       y_flip;
        logic       reuse_color;
        logic       next_seq;
        logic       use_latch_x;
        logic       use_latch_y;
        logic       inc_x;
        logic       inc_y;
    } obj_entry_t;

    // state set by command entries, bank is {a14, a13}
    typedef struct packed {
        logic       disabled;
        logic       flipscreen;
        logic [1:0] bank;
    } obj_ctrl_t;

    // one sprite placement for the rasteriser
    typedef struct packed {
        tile_code_t tile_code;
        coord_t     x;
        coord_t     y;
        color_t     color;
        logic       flip_x;
        logic       flip_y;
        mask16_t    row_mask;
        mask16_t    col_mask;
    } obj_place_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_PRE_READ,
        RD_READ
    } reader_state_t;

    typedef enum logic [2:0] {
        EV_IDLE,
        EV_BASE,
        EV_LATCH,
        EV_START,
        EV_WAIT
    } eval_state_t;

endpackage

`default_nettype wire

/* rtl/obj_zoom_calc.sv */
`default_nettype none

module obj_zoom_calc (
    input  wire logic        clk,
    input  wire logic        start,
    input  wire logic        cont,
    input  wire logic [8:0]  delta,
    output      logic        ready,
    output obj_pkg::mask16_t keep_mask,
    output      logic [4:0]  count
);

    logic [8:0] accum;
    logic [8:0] next_accum;
    logic [3:0] index;

    assign next_accum = accum + delta;

    always_ff @(posedge clk) begin
        if (start) begin
            ready     <= 1'b0;
            index     <= '0;
            count     <= '0;
            keep_mask <= '0;
            // a continued strip keeps the fractional phase
            if (!cont) begin
                accum <= '0;
            end
        end else if (!ready) begin
            accum <= next_accum;
            index <= index + 4'd1;
            // bit 8 flips once per whole output pixel
            if (next_accum[8] != accum[8]) begin
                keep_mask[index] <= 1'b1;
                count            <= count + 5'd1;
            end
            if (index == 4'd15) begin
                ready <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/obj_video_timing.sv */
`default_nettype none

module obj_video_timing (
    input  wire logic clk,
    input  wire logic RESET,
    input  wire logic ce_pixel,
    input  wire logic sync_fix,
    output      logic hsync_n,
    output      logic hbl_n,
    output      logic vsync_n,
    output      logic vbl_n,
    output      logic frame_start
);
    import obj_pkg::*;

    logic [8:0] hcnt;
    logic [8:0] vcnt;
    logic [6:0] hs_len;
    logic [2:0] vs_len;
    logic       line_end;

    // shorter pulses suit consumer monitors better
    assign hs_len   = sync_fix ? 7'(HS_LEN_FIX) : 7'(HS_LEN);
    assign vs_len   = sync_fix ? 3'(VS_LEN_FIX) : 3'(VS_LEN);
    assign line_end = (hcnt == 9'(H_TOTAL - 1));

    always_ff @(posedge clk) begin
        frame_start <= 1'b0;
        if (RESET) begin
            hcnt    <= '0;
            vcnt    <= '0;
            hsync_n <= 1'b1;
            hbl_n   <= 1'b1;
            vsync_n <= 1'b1;
            vbl_n   <= 1'b1;
        end else if (ce_pixel) begin
            if (line_end) begin
                hcnt <= '0;
                if (vcnt == 9'(V_TOTAL - 1)) begin
                    vcnt <= '0;
                end else begin
                    vcnt <= vcnt + 9'd1;
                end
                // step into the first vblank line starts a new list walk
                if (vcnt == 9'(VB_START - 1)) begin
                    frame_start <= 1'b1;
                end
            end else begin
                hcnt <= hcnt + 9'd1;
            end

            hsync_n <= !((hcnt >= HS_START) && (hcnt < HS_START + hs_len));
            // hblank wraps past the end of the line
            hbl_n   <= !((hcnt >= HB_START) || (hcnt <= HB_END));
            vsync_n <= !((vcnt >= VS_START) && (vcnt < VS_START + vs_len));
            vbl_n   <= !(vcnt >= VB_START);
        end
    end

endmodule

`default_nettype wire

/* rtl/obj_list_reader.sv */
`default_nettype none

module obj_list_reader (
    input  wire logic          clk,
    input  wire logic          RESET,
    input  wire logic          ce_13m,
    input  wire logic          frame_start,
    input  wire logic [15:0]   din,
    output obj_pkg::ram_addr_t  ra,
    output      logic          ram_cs_n,
    output      logic          busy,
    output      logic          entry_valid,
    output obj_pkg::obj_entry_t entry,
    output obj_pkg::obj_ctrl_t  ctrl
);
    import obj_pkg::*;

    reader_state_t state;
    logic [15:0]   words [WORDS_PER_ENTRY];
    logic [12:0]   obj_addr;
    entry_idx_t    entry_idx;
    logic [3:0]    wait_cnt;
    logic          zero_bank;
    logic          is_cmd;
    obj_ctrl_t     ctrl_reg;

    // word 7 is taken straight from din on its capture edge
    function automatic obj_entry_t decode_entry(input logic [15:0] w0, input logic [15:0] w1,
                                                input logic [15:0] w4, input logic [15:0] w6,
                                                input logic [15:0] w7);
        obj_entry_t e;
        e.tile_code    = w0[12:0];
        e.x_zoom       = w1[7:0];
        e.y_zoom       = w1[15:8];
        e.color        = w4[7:0];
        e.x_flip       = w4[8];
        e.y_flip       = w4[9];
        e.reuse_color  = w4[10];
        e.next_seq     = w4[11];
        e.use_latch_y  = w4[12];
        e.inc_y        = w4[13];
        e.use_latch_x  = w4[14];
        e.inc_x        = w4[15];
        e.x_coord      = w6[11:0];
        e.latch_extra  = w6[12];
        e.latch_master = w6[13];
        // both scroll bits are active low in RAM
        e.use_extra    = ~w6[14];
        e.use_scroll   = ~w6[15];
        e.y_coord      = w7[11:0];
        return e;
    endfunction

    assign entry_idx = obj_addr[12:3];
    assign ra = zero_bank ? {2'b00, obj_addr} : {ctrl_reg.bank, obj_addr};

    always_ff @(posedge clk) begin
        entry_valid <= 1'b0;
        if (RESET) begin
            state     <= RD_IDLE;
            obj_addr  <= '0;
            wait_cnt  <= '0;
            ram_cs_n  <= 1'b1;
            busy      <= 1'b0;
            zero_bank <= 1'b0;
            is_cmd    <= 1'b0;
            ctrl_reg  <= '0;
            ctrl      <= '0;
        end else if (frame_start) begin
            if (state == RD_IDLE) begin
                obj_addr <= '0;
                wait_cnt <= '0;
                busy     <= 1'b1;
                state    <= RD_PRE_READ;
            end else begin
                // walk overran the frame, give up on the rest
                ram_cs_n <= 1'b1;
                busy     <= 1'b0;
                state    <= RD_IDLE;
            end
        end else if (ce_13m) begin
            case (state)
                RD_PRE_READ: begin
                    wait_cnt <= wait_cnt + 4'd1;
                    if (wait_cnt == 4'(PRE_READ_WAIT - 1)) begin
                        ram_cs_n <= 1'b0;
                        state    <= RD_READ;
                    end
                end

                RD_READ: begin
                    words[obj_addr[2:0]] <= din;
                    obj_addr <= obj_addr + 13'd1;
                    case (obj_addr[2:0])
                        3'd3: begin
                            // command marker, bank bit clear reads bank 0 up to word 5
                            if (din[15]) begin
                                zero_bank <= ~din[0];
                                is_cmd    <= 1'b1;
                            end
                        end
                        3'd5: begin
                            if (is_cmd) begin
                                ctrl_reg.disabled   <= din[12];
                                ctrl_reg.flipscreen <= din[13];
                                ctrl_reg.bank       <= {din[0], din[10]};
                                zero_bank           <= 1'b0;
                                is_cmd              <= 1'b0;
                            end
                        end
                        3'd7: begin
                            entry       <= decode_entry(words[0], words[1], words[4],
                                                        words[6], din);
                            // control seen downstream changes only with a new entry
                            ctrl        <= ctrl_reg;
                            entry_valid <= 1'b1;
                            ram_cs_n    <= 1'b1;
                            wait_cnt    <= '0;
                            if (entry_idx == entry_idx_t'(NUM_ENTRIES - 1)) begin
                                busy  <= 1'b0;
                                state <= RD_IDLE;
                            end else begin
                                state <= RD_PRE_READ;
                            end
                        end
                        default: begin
                        end
                    endcase
                end

                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/obj_position_eval.sv */
`default_nettype none

module obj_position_eval (
    input  wire logic                clk,
    input  wire logic                RESET,
    input  wire logic                frame_start,
    input  wire logic                entry_valid,
    input  wire obj_pkg::obj_entry_t entry,
    input  wire obj_pkg::obj_ctrl_t  ctrl,
    output      logic                place_valid,
    output obj_pkg::obj_place_t      place
);
    import obj_pkg::*;

    eval_state_t state;
    logic        prev_seq;
    logic        seq_start;
    coord_t      master_x, master_y;
    coord_t      extra_x, extra_y;
    coord_t      scroll_x, scroll_y;
    coord_t      base_x, base_y;
    coord_t      latch_x, latch_y;
    color_t      latch_color;
    logic [8:0]  zoom_dx, zoom_dy;
    logic        row_start, row_cont, col_start, col_cont;
    logic        row_ready, col_ready;
    mask16_t     row_mask, col_mask;
    logic [4:0]  row_count, col_count;
    logic        skip;

    obj_zoom_calc row_calc (
        .clk       (clk),
        .start     (row_start),
        .cont      (row_cont),
        .delta     (zoom_dy),
        .ready     (row_ready),
        .keep_mask (row_mask),
        .count     (row_count)
    );

    obj_zoom_calc col_calc (
        .clk       (clk),
        .start     (col_start),
        .cont      (col_cont),
        .delta     (zoom_dx),
        .ready     (col_ready),
        .keep_mask (col_mask),
        .count     (col_count)
    );

    // scroll offset applied at a sequence start
    always_comb begin
        scroll_x = '0;
        scroll_y = '0;
        if (entry.use_scroll) begin
            scroll_x = entry.use_extra ? master_x + extra_x : master_x;
            scroll_y = entry.use_extra ? master_y + extra_y : master_y;
        end
    end

    assign skip = (entry.tile_code == '0) || ctrl.disabled ||
                  (latch_x > SCREEN_X_MAX) || (latch_y > SCREEN_Y_MAX);

    always_ff @(posedge clk) begin
        row_start   <= 1'b0;
        col_start   <= 1'b0;
        place_valid <= 1'b0;
        if (RESET) begin
            state    <= EV_IDLE;
            prev_seq <= 1'b0;
            extra_x  <= '0;
            extra_y  <= '0;
        end else begin
            if (frame_start) begin
                extra_x <= '0;
                extra_y <= '0;
            end
            case (state)
                EV_IDLE: begin
                    if (entry_valid) begin
                        seq_start <= ~prev_seq;
                        prev_seq  <= entry.next_seq;
                        state     <= EV_BASE;
                    end
                end

                EV_BASE: begin
                    if (seq_start) begin
                        base_x <= entry.x_coord + scroll_x;
                        base_y <= entry.y_coord + scroll_y;
                    end
                    if (entry.latch_master && !entry.use_scroll) begin
                        master_x <= entry.x_coord;
                        master_y <= entry.y_coord;
                    end
                    if (entry.latch_extra && !entry.use_extra) begin
                        extra_x <= entry.x_coord;
                        extra_y <= entry.y_coord;
                    end
                    state <= EV_LATCH;
                end

                EV_LATCH: begin
                    // counts still belong to the previous sprite here
                    latch_y <= entry.use_latch_y ? latch_y + coord_t'(row_count) : base_y;
                    if (entry.inc_x) begin
                        latch_x <= latch_x + coord_t'(col_count);
                    end else if (!entry.use_latch_x) begin
                        latch_x <= base_x;
                    end
                    if (!entry.reuse_color) begin
                        latch_color <= entry.color;
                    end
                    zoom_dx   <= 9'h100 - {1'b0, entry.x_zoom};
                    zoom_dy   <= 9'h100 - {1'b0, entry.y_zoom};
                    row_start <= 1'b1;
                    row_cont  <= ~seq_start & entry.inc_y;
                    col_start <= seq_start | entry.inc_x;
                    col_cont  <= ~seq_start & entry.inc_x;
                    state     <= EV_START;
                end

                // ready drops in the calculators on this edge
                EV_START: state <= EV_WAIT;

                EV_WAIT: begin
                    if (row_ready && col_ready) begin
                        if (!skip) begin
                            place_valid     <= 1'b1;
                            place.tile_code <= entry.tile_code;
                            place.x     <= ctrl.flipscreen ? FLIP_X_ORIGIN - latch_x : latch_x;
                            place.y     <= ctrl.flipscreen ? FLIP_Y_ORIGIN - latch_y : latch_y;
                            place.color    <= latch_color;
                            place.flip_x   <= entry.x_flip ^ ctrl.flipscreen;
                            place.flip_y   <= entry.y_flip ^ ctrl.flipscreen;
                            place.row_mask <= row_mask;
                            place.col_mask <= col_mask;
                        end
                        state <= EV_IDLE;
                    end
                end

                default: state <= EV_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/obj_engine.sv */
`default_nettype none

module obj_engine (
    input  wire logic          clk,
    input  wire logic          RESET,
    input  wire logic          ce_13m,
    input  wire logic          ce_pixel,
    input  wire logic          sync_fix,
    output obj_pkg::ram_addr_t  ra,
    input  wire logic [15:0]   din,
    output      logic          ram_cs_n,
    output      logic          busy,
    output      logic          hsync_n,
    output      logic          hbl_n,
    output      logic          vsync_n,
    output      logic          vbl_n,
    output      logic          place_valid,
    output obj_pkg::obj_place_t place
);
    import obj_pkg::*;

    logic       frame_start;
    logic       entry_valid;
    obj_entry_t entry;
    obj_ctrl_t  ctrl;

    obj_video_timing i_video_timing (
        .clk         (clk),
        .RESET       (RESET),
        .ce_pixel    (ce_pixel),
        .sync_fix    (sync_fix),
        .hsync_n     (hsync_n),
        .hbl_n       (hbl_n),
        .vsync_n     (vsync_n),
        .vbl_n       (vbl_n),
        .frame_start (frame_start)
    );

    obj_list_reader i_list_reader (
        .clk         (clk),
        .RESET       (RESET),
        .ce_13m      (ce_13m),
        .frame_start (frame_start),
        .din         (din),
        .ra          (ra),
        .ram_cs_n    (ram_cs_n),
        .busy        (busy),
        .entry_valid (entry_valid),
        .entry       (entry),
        .ctrl        (ctrl)
    );

    // extra scroll is cleared on the same frame pulse that starts the walk
    obj_position_eval i_position_eval (
        .clk         (clk),
        .RESET       (RESET),
        .frame_start (frame_start),
        .entry_valid (entry_valid),
        .entry       (entry),
        .ctrl        (ctrl),
        .place_valid (place_valid),
        .place       (place)
    );

endmodule

`default_nettype wire

/* tests/tb_obj_engine.sv */
`default_nettype none

module tb_obj_engine;
    timeunit 1ns;
    timeprecision 1ps;
    import obj_pkg::*;

    localparam longint TIMEOUT_NS = 64'(4 * H_TOTAL * V_TOTAL * 2 * 10);

    logic        clk, RESET, ce_13m, ce_pixel, sync_fix;
    ram_addr_t   ra;
    logic [15:0] din;
    logic        ram_cs_n, busy, hsync_n, hbl_n, vsync_n, vbl_n, place_valid;
    obj_place_t  place;

    logic [15:0] ram [32768];
    obj_place_t  exp_q[$];
    integer      seed = 32'hff92_db1e;
    int          errors = 0;
    int          checks = 0;
    int          walks_done = 0;
    int          vbl_checks = 0;
    int          hs_fix_checks = 0;
    int          vs_fix_checks = 0;
    logic        busy_q = 1'b0;

    // reference model state, carried from one walk to the next
    logic [1:0]  m_bank = '0;
    logic        m_dis = 1'b0, m_flip = 1'b0, m_zero = 1'b0, m_cmd = 1'b0, m_prev = 1'b0;
    coord_t      mx, my, ex, ey, bx, by, lx, ly;
    color_t      lcol;
    logic [8:0]  racc, cacc;
    mask16_t     rmask, cmask;
    logic [4:0]  rcnt, ccnt;

    obj_engine i_obj_engine (
        .clk(clk), .RESET(RESET), .ce_13m(ce_13m), .ce_pixel(ce_pixel),
        .sync_fix(sync_fix), .ra(ra), .din(din), .ram_cs_n(ram_cs_n), .busy(busy),
        .hsync_n(hsync_n), .hbl_n(hbl_n), .vsync_n(vsync_n), .vbl_n(vbl_n),
        .place_valid(place_valid), .place(place)
    );

    // sprite RAM answers combinationally
    assign din = ram[ra];

    always #5 clk = ~clk;

    always @(posedge clk) ce_pixel <= ~ce_pixel;

    task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                   input logic [127:0] got_v);
        errors++;
        $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp_v, got_v);
    endtask

    task automatic put_entry(input logic [1:0] bank, input int idx, input logic [15:0] w0,
                             input logic [15:0] w1, input logic [15:0] w3,
                             input logic [15:0] w4, input logic [15:0] w5,
                             input logic [15:0] w6, input logic [15:0] w7);
        logic [14:0] a;
        a = {bank, 13'(idx * 8)};
        ram[a]     = w0;
        ram[a + 1] = w1;
        ram[a + 3] = w3;
        ram[a + 4] = w4;
        ram[a + 5] = w5;
        ram[a + 6] = w6;
        ram[a + 7] = w7;
    endtask

    // accumulator rule: source i is kept when bit 8 of the sum changes
    task automatic zoom_rule(input logic [8:0] delta, input logic cont,
                             inout logic [8:0] acc, output mask16_t mask,
                             output logic [4:0] cnt);
        logic [8:0] nxt;
        mask = '0;
        cnt  = '0;
        if (!cont) acc = '0;
        for (int i = 0; i < 16; i++) begin
            nxt = acc + delta;
            if (nxt[8] != acc[8]) begin
                mask[i] = 1'b1;
                cnt     = cnt + 5'd1;
            end
            acc = nxt;
        end
    endtask

    task automatic model_walk();
        logic [15:0] w [8];
        logic [12:0] a;
        logic        seq, use_scroll, use_extra;
        coord_t      x, y, sx, sy;
        obj_place_t  p;
        ex = '0;
        ey = '0;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            for (int k = 0; k < 8; k++) begin
                a = 13'(e * 8 + k);
                w[k] = m_zero ? ram[{2'b00, a}] : ram[{m_bank, a}];
                if (k == 3 && w[3][15]) begin
                    m_zero = ~w[3][0];
                    m_cmd  = 1'b1;
                end
                if (k == 5 && m_cmd) begin
                    m_dis  = w[5][12];
                    m_flip = w[5][13];
                    m_bank = {w[5][0], w[5][10]};
                    m_zero = 1'b0;
                    m_cmd  = 1'b0;
                end
            end
            seq        = ~m_prev;
            m_prev     = w[4][11];
            use_scroll = ~w[6][15];
            use_extra  = ~w[6][14];
            x          = w[6][11:0];
            y          = w[7][11:0];
            if (seq) begin
                sx = use_scroll ? (use_extra ? mx + ex : mx) : '0;
                sy = use_scroll ? (use_extra ? my + ey : my) : '0;
                bx = x + sx;
                by = y + sy;
            end
            if (w[6][13] && !use_scroll) begin
                mx = x;
                my = y;
            end
            if (w[6][12] && !use_extra) begin
                ex = x;
                ey = y;
            end
            ly = w[4][12] ? ly + coord_t'(rcnt) : by;
            if (w[4][15]) lx = lx + coord_t'(ccnt);
            else if (!w[4][14]) lx = bx;
            if (!w[4][10]) lcol = w[4][7:0];
            zoom_rule(9'h100 - {1'b0, w[1][15:8]}, !seq && w[4][13], racc, rmask, rcnt);
            if (seq || w[4][15]) begin
                zoom_rule(9'h100 - {1'b0, w[1][7:0]}, !seq && w[4][15], cacc, cmask, ccnt);
            end
            if (w[0][12:0] != '0 && !m_dis && lx <= SCREEN_X_MAX && ly <= SCREEN_Y_MAX) begin
                p.tile_code = w[0][12:0];
                p.x         = m_flip ? FLIP_X_ORIGIN - lx : lx;
                p.y         = m_flip ? FLIP_Y_ORIGIN - ly : ly;
                p.color     = lcol;
                p.flip_x    = w[4][8] ^ m_flip;
                p.flip_y    = w[4][9] ^ m_flip;
                p.row_mask  = rmask;
                p.col_mask  = cmask;
                exp_q.push_back(p);
            end
        end
    endtask

    task automatic fill_ram();
        logic [15:0] r;
        foreach (ram[i]) ram[i] = '0;
        // absolute sprite, then master latch and a scrolled sprite
        put_entry(0, 0, 16'd5, 16'h0000, 0, 16'h0012, 0, 16'hC000 | 16'd100, 16'd50);
        put_entry(0, 1, 16'd0, 16'h0000, 0, 16'h0000, 0, 16'hE000 | 16'd30, 16'd20);
        put_entry(0, 2, 16'd7, 16'h0000, 0, 16'h0034, 0, 16'h4000 | 16'd40, 16'd60);
        // extra latch, then a sprite with both scrolls
        put_entry(0, 3, 16'd0, 16'h0000, 0, 16'h0000, 0, 16'hD000 | 16'd5, 16'd6);
        put_entry(0, 4, 16'd9, 16'h0000, 0, 16'h0056, 0, 16'h0000 | 16'd10, 16'd10);
        // zoomed sprites, the first at half size
        put_entry(0, 5, 16'd11, 16'h8080, 0, 16'h0078, 0, 16'hC000 | 16'd64, 16'd32);
        for (int e = 6; e < 13; e++) begin
            r = 16'($random(seed));
            put_entry(0, e, 16'(100 + e), r, 0, 16'($random(seed)) & 16'h03FF, 0,
                      16'hC000 | 16'($unsigned($random(seed)) % 400),
                      16'($unsigned($random(seed)) % 200));
        end
        // tile 0 and off-screen entries
        put_entry(0, 13, 16'd0, 0, 0, 16'h0011, 0, 16'hC000 | 16'd20, 16'd20);
        put_entry(0, 14, 16'd12, 0, 0, 16'h0011, 0, 16'hC000 | 16'd500, 16'd20);
        put_entry(0, 15, 16'd13, 0, 0, 16'h0011, 0, 16'hC000 | 16'd20, 16'd250);
        // disable on, a hidden sprite, disable off, a visible sprite
        put_entry(0, 16, 16'd0, 0, 16'h8001, 0, 16'h1000, 16'hC000, 0);
        put_entry(0, 17, 16'd14, 0, 0, 16'h0022, 0, 16'hC000 | 16'd80, 16'd90);
        put_entry(0, 18, 16'd0, 0, 16'h8001, 0, 16'h0000, 16'hC000, 0);
        put_entry(0, 19, 16'd15, 0, 0, 16'h0023, 0, 16'hC000 | 16'd81, 16'd91);
        // flipscreen on and a flipped sprite
        put_entry(0, 20, 16'd0, 0, 16'h8001, 0, 16'h2000, 16'hC000, 0);
        put_entry(0, 21, 16'd16, 0, 0, 16'h0124, 0, 16'hC000 | 16'd200, 16'd100);
        // flipscreen off and bank 3, the upper copy of entry 23 is the one read
        put_entry(0, 22, 16'd0, 0, 16'h8000, 0, 16'h0401, 16'hC000, 0);
        put_entry(0, 23, 16'h111, 0, 0, 16'h0031, 0, 16'hC000 | 16'd33, 16'd44);
        put_entry(3, 23, 16'h222, 0, 0, 16'h0032, 0, 16'hC000 | 16'd55, 16'd66);
        // back to bank 0 for the next frame
        put_entry(3, 24, 16'd0, 0, 16'h8001, 0, 16'h0000, 16'hC000, 0);
    endtask

    // placement checks
    always @(posedge clk) begin
        busy_q <= busy;
        if (busy_q && !busy) walks_done <= walks_done + 1;
        if (place_valid) begin
            checks++;
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("Unexpected placement at %0t ns with tile %h", $time, place.tile_code);
            end
            if (exp_q.size() > 0) begin
                assert (place == exp_q[0]) else report_mismatch("place", exp_q[0], place);
                void'(exp_q.pop_front());
            end
        end
    end

    // chip select and busy widths, ce_13m is high on every clk
    int cs_cnt = 0;
    int busy_cnt = 0;

    always @(posedge clk) begin
        if (!RESET) begin
            if (!ram_cs_n) begin
                cs_cnt++;
            end else if (cs_cnt != 0) begin
                checks++;
                assert (cs_cnt == WORDS_PER_ENTRY)
                    else report_mismatch("ram_cs_n width", WORDS_PER_ENTRY, cs_cnt);
                cs_cnt = 0;
            end
            if (busy) begin
                busy_cnt++;
            end else if (busy_cnt != 0) begin
                checks++;
                assert (busy_cnt == NUM_ENTRIES * (PRE_READ_WAIT + WORDS_PER_ENTRY))
                    else report_mismatch("busy width",
                                         NUM_ENTRIES * (PRE_READ_WAIT + WORDS_PER_ENTRY),
                                         busy_cnt);
                busy_cnt = 0;
            end
        end
    end

    // sync and blank widths, counted in ce_pixel periods
    int   hs_cnt = 0, vs_cnt = 0, vb_cnt = 0, hb_cnt = 0;
    logic fix_q = 1'b0, skip_h = 1'b0, skip_v = 1'b0;
    // first hblank after reset starts mid-window
    logic skip_b = 1'b1;

    always @(posedge clk) begin
        if (sync_fix != fix_q) begin
            skip_h = 1'b1;
            skip_v = 1'b1;
        end
        fix_q = sync_fix;
        if (!RESET && ce_pixel) begin
            if (!hsync_n) begin
                hs_cnt++;
            end else if (hs_cnt != 0) begin
                if (!skip_h) begin
                    checks++;
                    if (sync_fix) hs_fix_checks++;
                    assert (hs_cnt == (sync_fix ? HS_LEN_FIX : HS_LEN))
                        else report_mismatch("hsync_n width", sync_fix ? HS_LEN_FIX : HS_LEN,
                                             hs_cnt);
                end
                skip_h = 1'b0;
                hs_cnt = 0;
            end
            if (!hbl_n) begin
                hb_cnt++;
            end else if (hb_cnt != 0) begin
                if (!skip_b) begin
                    checks++;
                    assert (hb_cnt == H_TOTAL - HB_START + HB_END + 1)
                        else report_mismatch("hbl_n width", H_TOTAL - HB_START + HB_END + 1,
                                             hb_cnt);
                end
                skip_b = 1'b0;
                hb_cnt = 0;
            end
            if (!vsync_n) begin
                vs_cnt++;
            end else if (vs_cnt != 0) begin
                if (!skip_v) begin
                    checks++;
                    if (sync_fix) vs_fix_checks++;
                    assert (vs_cnt == (sync_fix ? VS_LEN_FIX : VS_LEN) * H_TOTAL)
                        else report_mismatch("vsync_n width",
                                             (sync_fix ? VS_LEN_FIX : VS_LEN) * H_TOTAL, vs_cnt);
                end
                skip_v = 1'b0;
                vs_cnt = 0;
            end
            if (!vbl_n) begin
                vb_cnt++;
            end else if (vb_cnt != 0) begin
                checks++;
                vbl_checks++;
                assert (vb_cnt == (V_TOTAL - VB_START) * H_TOTAL)
                    else report_mismatch("vbl_n width", (V_TOTAL - VB_START) * H_TOTAL, vb_cnt);
                vb_cnt = 0;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within four frames");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        clk      = 1'b0;
        RESET    = 1'b1;
        ce_13m   = 1'b0;
        ce_pixel = 1'b0;
        sync_fix = 1'b0;
        fill_ram();
        for (int i = 0; i < 3; i++) model_walk();
        repeat (5) @(posedge clk);
        RESET  <= 1'b0;
        ce_13m <= 1'b1;
        wait (walks_done >= 2);
        @(posedge clk);
        sync_fix <= 1'b1;
        wait (walks_done >= 3 && vbl_checks >= 3);
        repeat (40) @(posedge clk);
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("Missing placements: %0d expected placements never appeared", exp_q.size());
        end
        assert (hs_fix_checks > 0 && vs_fix_checks > 0) else begin
            errors++;
            $display("Sync widths with sync_fix raised were never measured");
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
rtl/obj_pkg.sv
rtl/obj_zoom_calc.sv
rtl/obj_video_timing.sv
rtl/obj_list_reader.sv
rtl/obj_position_eval.sv
rtl/obj_engine.sv
tests/tb_obj_engine.sv

/* Bender.yml */
package:
  name: obj_engine

sources:
  - rtl/obj_pkg.sv
  - rtl/obj_zoom_calc.sv
  - rtl/obj_video_timing.sv
  - rtl/obj_list_reader.sv
  - rtl/obj_position_eval.sv
  - rtl/obj_engine.sv
  - target: test
    files:
      - tests/tb_obj_engine.sv
